// ==== verilog/mipsCore_macros.svh ====
// widths, reset address and stage levels, included by the core RTL files
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

// data path and address width
`define MIPS_XLEN 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// stage levels, used for result-ready and operand-need timing
`define LEVEL_D 3'd0
`define LEVEL_E 3'd1
`define LEVEL_M 3'd2
`define LEVEL_W 3'd3

`endif

// ==== verilog/mipsPkg.sv ====
// shared encodings and decoded control struct, referenced by scoped name
package mipsPkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeT;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functT;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI} aluOpT;
    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extOpT;
    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JUMP, BR_REG} branchModeT;
    typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_PC8} wdSelT;
    typedef enum logic [1:0] {FWD_NONE, FWD_FROM_M, FWD_FROM_W} fwdSelT;
    typedef enum logic [1:0] {WT_RT, WT_RD, WT_RA} wtSelT;  // destination register field

    typedef struct packed {
        branchModeT branchMode;
        logic       brNotEq;      // bne instead of beq
        extOpT      extOp;
        logic       aluSrcImm;    // b operand from immediate
        aluOpT      aluOp;
        logic       memWrite;
        logic       regWrite;
        wtSelT      wtSel;
        wdSelT      wdSel;
        logic [2:0] resultLevel;  // stage producing the result
    } ctrlT;

endpackage

// ==== verilog/hazardIf.sv ====
// hazard unit operands and results, shared by the core and the hazard unit
interface hazardIf;
    logic [4:0]      dRsNum, dRtNum;
    logic            dUseRs, dUseRt;
    logic [2:0]      dUseAtRs, dUseAtRt;
    logic [4:0]      eRsNum, eRtNum;
    logic [4:0]      eDest;
    logic            eWe;
    logic [2:0]      eLevel;
    logic [4:0]      mRtNum;
    logic [4:0]      mDest;
    logic            mWe;
    logic [2:0]      mLevel;
    logic            mFwdOk;      // memory stage result is forwardable
    logic [4:0]      wNum;
    logic            wWe;
    logic            stall;
    mipsPkg::fwdSelT fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt;

    modport core (
        output dRsNum, dRtNum, dUseRs, dUseRt, dUseAtRs, dUseAtRt,
        output eRsNum, eRtNum, eDest, eWe, eLevel,
        output mRtNum, mDest, mWe, mLevel, mFwdOk, wNum, wWe,
        input  stall, fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt
    );
    modport unit (
        input  dRsNum, dRtNum, dUseRs, dUseRt, dUseAtRs, dUseAtRt,
        input  eRsNum, eRtNum, eDest, eWe, eLevel,
        input  mRtNum, mDest, mWe, mLevel, mFwdOk, wNum, wWe,
        output stall, fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt
    );
endinterface

// ==== verilog/controller.sv ====
// instruction decoder for the decode stage, gives control fields and operand timing
`include "mipsCore_macros.svh"

module controller (
    input  logic [31:0]   inst,
    output mipsPkg::ctrlT ctrl,
    output logic          useRs,
    output logic          useRt,
    output logic [2:0]    useAtRs,
    output logic [2:0]    useAtRt
);
    always_comb begin
        ctrl = '0;                      // no-op unless matched below
        ctrl.resultLevel = `LEVEL_E;
        useRs = 1'b0;
        useRt = 1'b0;
        useAtRs = `LEVEL_E;
        useAtRt = `LEVEL_E;
        case (mipsPkg::opcodeT'(inst[31:26]))
            mipsPkg::OP_SPECIAL: begin
                ctrl.wtSel = mipsPkg::WT_RD;
                ctrl.regWrite = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
                case (mipsPkg::functT'(inst[5:0]))
                    mipsPkg::FN_ADDU: ctrl.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: ctrl.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  ctrl.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   ctrl.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT:  ctrl.aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLL: begin
                        ctrl.aluOp = mipsPkg::ALU_SLL;
                        useRs = 1'b0;               // shifts rt only
                    end
                    mipsPkg::FN_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.branchMode = mipsPkg::BR_REG;
                        useRt = 1'b0;
                        useAtRs = `LEVEL_D;         // target needed in decode
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                        useRs = 1'b0;
                        useRt = 1'b0;
                    end
                endcase
            end
            mipsPkg::OP_J: ctrl.branchMode = mipsPkg::BR_JUMP;
            mipsPkg::OP_JAL: begin
                ctrl.branchMode = mipsPkg::BR_JUMP;
                ctrl.regWrite = 1'b1;
                ctrl.wtSel = mipsPkg::WT_RA;
                ctrl.wdSel = mipsPkg::WD_PC8;
                ctrl.resultLevel = `LEVEL_D;    // link value known at decode
            end
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                ctrl.branchMode = mipsPkg::BR_COND;
                ctrl.brNotEq = inst[26];        // bne differs in the low opcode bit
                ctrl.extOp = mipsPkg::EXT_SIGN;
                useRs = 1'b1;
                useRt = 1'b1;
                useAtRs = `LEVEL_D;
                useAtRt = `LEVEL_D;
            end
            mipsPkg::OP_ADDIU, mipsPkg::OP_ORI, mipsPkg::OP_LUI, mipsPkg::OP_LW: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                useRs = inst[31:26] != mipsPkg::OP_LUI;
                case (mipsPkg::opcodeT'(inst[31:26]))
                    mipsPkg::OP_ORI: ctrl.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::OP_LUI: ctrl.aluOp = mipsPkg::ALU_LUI;   // zero-extended imm
                    default:         ctrl.extOp = mipsPkg::EXT_SIGN;
                endcase
                if (inst[31:26] == mipsPkg::OP_LW) begin
                    ctrl.wdSel = mipsPkg::WD_MEM;
                    ctrl.resultLevel = `LEVEL_M;
                end
            end
            mipsPkg::OP_SW: begin
                ctrl.extOp = mipsPkg::EXT_SIGN;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
                useAtRt = `LEVEL_M;             // store data needed in memory
            end
            default: ;
        endcase
    end
endmodule

// ==== verilog/regFile.sv ====
// 32 x 32 register file, written in writeback and read in decode
`include "mipsCore_macros.svh"

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [4:0]            rsNum,
    input  logic [4:0]            rtNum,
    output logic [`MIPS_XLEN-1:0] rsData,
    output logic [`MIPS_XLEN-1:0] rtData,
    input  logic                  wrEn,
    input  logic [4:0]            wrNum,
    input  logic [`MIPS_XLEN-1:0] wrData
);
    logic [`MIPS_XLEN-1:0] regs [32];

    // same-cycle write is visible to decode
    function automatic logic [`MIPS_XLEN-1:0] readPort(input logic [4:0] num);
        if (num == 5'd0)
            readPort = '0;
        else if (wrEn && wrNum == num)
            readPort = wrData;
        else
            readPort = regs[num];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEn && wrNum != 5'd0) begin
            regs[wrNum] <= wrData;
        end
    end

    assign rsData = readPort(rsNum);
    assign rtData = readPort(rtNum);
endmodule

// ==== verilog/alu.sv ====
// integer ALU of the execute stage
`include "mipsCore_macros.svh"

module alu (
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  logic [4:0]            shamt,
    input  mipsPkg::aluOpT        op,
    output logic [`MIPS_XLEN-1:0] result
);
    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mipsPkg::ALU_ADD: result = a + b;
            mipsPkg::ALU_SUB: result = a - b;
            mipsPkg::ALU_AND: result = a & b;
            mipsPkg::ALU_OR:  result = a | b;
            mipsPkg::ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
            mipsPkg::ALU_SLL: result = b << shamt;    // sll shifts rt
            mipsPkg::ALU_LUI: result = b << 16;
            default:          result = a + b;
        endcase
    end
endmodule

// ==== verilog/hazardUnit.sv ====
// stall and forwarding decisions for the pipelined core
`include "mipsCore_macros.svh"

module hazardUnit (
    hazardIf.unit hz
);
    logic stallE, stallM;

    // operand waits on an in-flight producer that cannot deliver in time
    function automatic logic waitOn(
        input logic       inUse,
        input logic [4:0] num,
        input logic [2:0] useAt,
        input logic       we,
        input logic [4:0] dest,
        input logic [2:0] at,
        input logic [2:0] level
    );
        logic [2:0] ready;
        // earliest forward point is the memory stage
        ready = (level < `LEVEL_E) ? `LEVEL_E : level;
        waitOn = inUse && num != 5'd0 && we && dest == num && (at + useAt <= ready);
    endfunction

    // memory stage wins over writeback
    function automatic mipsPkg::fwdSelT pickSrc(input logic [4:0] num);
        if (num == 5'd0)
            pickSrc = mipsPkg::FWD_NONE;
        else if (hz.mFwdOk && hz.mDest == num)
            pickSrc = mipsPkg::FWD_FROM_M;
        else if (hz.wWe && hz.wNum == num)
            pickSrc = mipsPkg::FWD_FROM_W;
        else
            pickSrc = mipsPkg::FWD_NONE;
    endfunction

    assign stallE = waitOn(hz.dUseRs, hz.dRsNum, hz.dUseAtRs, hz.eWe, hz.eDest, `LEVEL_E,
                           hz.eLevel)
                 || waitOn(hz.dUseRt, hz.dRtNum, hz.dUseAtRt, hz.eWe, hz.eDest, `LEVEL_E,
                           hz.eLevel);
    assign stallM = waitOn(hz.dUseRs, hz.dRsNum, hz.dUseAtRs, hz.mWe, hz.mDest, `LEVEL_M,
                           hz.mLevel)
                 || waitOn(hz.dUseRt, hz.dRtNum, hz.dUseAtRt, hz.mWe, hz.mDest, `LEVEL_M,
                           hz.mLevel);
    assign hz.stall = stallE || stallM;

    assign hz.fwdDRs = pickSrc(hz.dRsNum);
    assign hz.fwdDRt = pickSrc(hz.dRtNum);
    assign hz.fwdERs = pickSrc(hz.eRsNum);
    assign hz.fwdERt = pickSrc(hz.eRtNum);

    // store data in memory only sees writeback
    assign hz.fwdMRt = (hz.mRtNum != 5'd0 && hz.wWe && hz.wNum == hz.mRtNum)
                     ? mipsPkg::FWD_FROM_W : mipsPkg::FWD_NONE;
endmodule

// ==== verilog/mipsCore.sv ====
// five-stage MIPS core top, instruction and data memories connect outside
`include "mipsCore_macros.svh"

module mipsCore (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`MIPS_XLEN-1:0] imemAddr,
    input  logic [`MIPS_XLEN-1:0] imemData,
    output logic [`MIPS_XLEN-1:0] dmemAddr,
    output logic [`MIPS_XLEN-1:0] dmemWdata,
    output logic                  dmemWe,
    input  logic [`MIPS_XLEN-1:0] dmemRdata,
    output logic                  wbEn,
    output logic [4:0]            wbNum,
    output logic [`MIPS_XLEN-1:0] wbData,
    output logic [`MIPS_XLEN-1:0] wbPc
);
    hazardIf hz();

    logic [`MIPS_XLEN-1:0] pc, branchTarget, fdPc, fdInst, dPc4;
    logic [`MIPS_XLEN-1:0] rfRs, rfRt, dRsVal, dRtVal, dImm;
    logic [`MIPS_XLEN-1:0] dePc, deRsVal, deRtVal, deImm, eRsVal, eRtVal, aluB, aluOut;
    logic [`MIPS_XLEN-1:0] emPc, emAlu, emRtVal, mPc8, mFwdData, mResult;
    logic [`MIPS_XLEN-1:0] mwPc, mwData;
    logic                  takeBranch, fdValid, deValid, emValid, mwValid, mwRegWrite;
    logic                  useRs, useRt;
    logic [2:0]            useAtRs, useAtRt;
    logic [4:0]            dDest, deRs, deRt, deShamt, deDest, emRt, emDest, mwNum;
    mipsPkg::ctrlT         dCtrl, deCtrl, emCtrl;

    function automatic logic [`MIPS_XLEN-1:0] fwdMux(
        input mipsPkg::fwdSelT       sel,
        input logic [`MIPS_XLEN-1:0] base,
        input logic [`MIPS_XLEN-1:0] fromM,
        input logic [`MIPS_XLEN-1:0] fromW
    );
        case (sel)
            mipsPkg::FWD_FROM_M: fwdMux = fromM;
            mipsPkg::FWD_FROM_W: fwdMux = fromW;
            default:             fwdMux = base;
        endcase
    endfunction

    // fetch, pc holds while decode waits
    assign imemAddr = pc;
    always_ff @(posedge clk) begin
        if (reset)
            pc <= `MIPS_RESET_PC;
        else if (!hz.stall)
            pc <= takeBranch ? branchTarget : pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (reset)
            fdValid <= 1'b0;
        else if (!hz.stall)
            fdValid <= 1'b1;
    end
    always_ff @(posedge clk) begin
        if (!hz.stall) begin
            fdPc <= pc;
            fdInst <= imemData;
        end
    end

    // decode
    controller controller_i (
        .inst(fdInst), .ctrl(dCtrl),
        .useRs(useRs), .useRt(useRt), .useAtRs(useAtRs), .useAtRt(useAtRt)
    );
    regFile regFile_i (
        .clk(clk), .reset(reset),
        .rsNum(fdInst[25:21]), .rtNum(fdInst[20:16]),
        .rsData(rfRs), .rtData(rfRt),
        .wrEn(wbEn), .wrNum(mwNum), .wrData(mwData)
    );
    assign dRsVal = fwdMux(hz.fwdDRs, rfRs, mFwdData, mwData);
    assign dRtVal = fwdMux(hz.fwdDRt, rfRt, mFwdData, mwData);
    assign dPc4 = fdPc + 32'd4;

    always_comb begin
        case (dCtrl.extOp)
            mipsPkg::EXT_SIGN: dImm = {{16{fdInst[15]}}, fdInst[15:0]};
            default:           dImm = {16'h0000, fdInst[15:0]};
        endcase
        case (dCtrl.wtSel)
            mipsPkg::WT_RD: dDest = fdInst[15:11];
            mipsPkg::WT_RA: dDest = 5'd31;
            default:        dDest = fdInst[20:16];
        endcase
    end

    // branches resolve here, the delay slot is already in fetch
    always_comb begin
        takeBranch = 1'b0;
        branchTarget = dPc4 + {dImm[29:0], 2'b00};
        case (dCtrl.branchMode)
            mipsPkg::BR_COND: takeBranch = fdValid && ((dRsVal == dRtVal) != dCtrl.brNotEq);
            mipsPkg::BR_JUMP: begin
                takeBranch = fdValid;
                branchTarget = {dPc4[31:28], fdInst[25:0], 2'b00};
            end
            mipsPkg::BR_REG: begin
                takeBranch = fdValid;
                branchTarget = dRsVal;
            end
            default: ;
        endcase
    end

    // stall turns execute into a bubble
    always_ff @(posedge clk) begin
        deValid <= !reset && !hz.stall && fdValid;
        emValid <= !reset && deValid;
        mwValid <= !reset && emValid;
    end
    always_ff @(posedge clk) begin
        dePc <= fdPc;
        deRsVal <= dRsVal;
        deRtVal <= dRtVal;
        deImm <= dImm;
        deRs <= fdInst[25:21];
        deRt <= fdInst[20:16];
        deShamt <= fdInst[10:6];
        deDest <= dDest;
        deCtrl <= dCtrl;
        emPc <= dePc;
        emAlu <= aluOut;
        emRtVal <= eRtVal;
        emRt <= deRt;
        emDest <= deDest;
        emCtrl <= deCtrl;
        mwPc <= emPc;
        mwData <= mResult;
        mwNum <= emDest;
        mwRegWrite <= emCtrl.regWrite;
    end

    // execute
    assign eRsVal = fwdMux(hz.fwdERs, deRsVal, mFwdData, mwData);
    assign eRtVal = fwdMux(hz.fwdERt, deRtVal, mFwdData, mwData);
    assign aluB = deCtrl.aluSrcImm ? deImm : eRtVal;
    alu alu_i (.a(eRsVal), .b(aluB), .shamt(deShamt), .op(deCtrl.aluOp), .result(aluOut));

    // memory
    assign mPc8 = emPc + 32'd8;
    assign mFwdData = (emCtrl.wdSel == mipsPkg::WD_PC8) ? mPc8 : emAlu;
    assign mResult = (emCtrl.wdSel == mipsPkg::WD_MEM) ? dmemRdata : mFwdData;
    assign dmemAddr = emAlu;
    assign dmemWdata = fwdMux(hz.fwdMRt, emRtVal, mFwdData, mwData);
    assign dmemWe = emValid && emCtrl.memWrite;

    // writeback, r0 writes are dropped
    assign wbEn = mwValid && mwRegWrite && mwNum != 5'd0;
    assign wbNum = mwNum;
    assign wbData = mwData;
    assign wbPc = mwPc;

    assign hz.dRsNum = fdInst[25:21];
    assign hz.dRtNum = fdInst[20:16];
    assign hz.dUseRs = fdValid && useRs;
    assign hz.dUseRt = fdValid && useRt;
    assign hz.dUseAtRs = useAtRs;
    assign hz.dUseAtRt = useAtRt;
    assign hz.eRsNum = deRs;
    assign hz.eRtNum = deRt;
    assign hz.eDest = deDest;
    assign hz.eWe = deValid && deCtrl.regWrite;
    assign hz.eLevel = deCtrl.resultLevel;
    assign hz.mRtNum = emRt;
    assign hz.mDest = emDest;
    assign hz.mWe = emValid && emCtrl.regWrite;
    assign hz.mLevel = emCtrl.resultLevel;
    assign hz.mFwdOk = hz.mWe && emCtrl.resultLevel <= `LEVEL_E;  // loads not yet
    assign hz.wNum = mwNum;
    assign hz.wWe = wbEn;

    hazardUnit hazardUnit_i (.hz(hz.unit));
endmodule

// ==== dv/mipsCoreTb.sv ====
// testbench for mipsCore, runs a directed and a random program against an ISA model
`include "mipsCore_macros.svh"

module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int imemWords = 4096;
    localparam int randomCount = 2000;
    localparam int modelSteps = 20000;
    localparam int runCycles = 30000;

    logic        clk;
    logic        reset;
    logic [31:0] imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata, wbData, wbPc;
    logic        dmemWe, wbEn;
    logic [4:0]  wbNum;

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [64];
    logic [31:0] refMem [64];   // model's own copy of the data window
    logic [31:0] gpr [32];
    logic [31:0] refPc, refNpc;
    logic [68:0] wbQ [$];       // pc, register, value
    logic [63:0] stQ [$];       // address, data
    int          progLen;
    int          haltIdx;
    int          posEdges;

    mipsCore mipsCore_i (
        .clk(clk), .reset(reset),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata),
        .wbEn(wbEn), .wbNum(wbNum), .wbData(wbData), .wbPc(wbPc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_PC;
        if (offset < 32'(imemWords * 4))
            fetchWord = imem[offset[13:2]];
        else
            fetchWord = 32'h0000_0000;   // nop outside the program
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        fillWord = 32'h5a00_0000 ^ (32'(idx) * 32'h0104_1041);
    endfunction

    assign imemData = fetchWord(imemAddr);
    assign dmemRdata = dmem[dmemAddr[7:2]];   // 64-word window, wraps

    always @(posedge clk) begin
        if (dmemWe)
            dmem[dmemAddr[7:2]] <= dmemWdata;
        if (!reset)
            posEdges <= posEdges + 1;
    end

    task automatic stopWithFail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stopWithFail();
        end
    endtask

    function automatic logic [31:0] rType(input mipsPkg::functT fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        rType = {mipsPkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input mipsPkg::opcodeT op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        iType = {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input mipsPkg::opcodeT op, input logic [31:0] addr);
        jType = {op, addr[27:2]};
    endfunction

    function automatic logic [31:0] addrOf(input int idx);
        addrOf = `MIPS_RESET_PC + 32'(idx) * 32'd4;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // dependency chains, stores, loads, branches and jumps
    task automatic buildDirected();
        int          b;
        logic [31:0] jrTarget;
        emit(iType(mipsPkg::OP_LUI, 5'd0, 5'd1, 16'h8234));   // negative upper half
        emit(iType(mipsPkg::OP_ORI, 5'd1, 5'd1, 16'h5678));
        emit(iType(mipsPkg::OP_ADDIU, 5'd1, 5'd2, 16'hfffd));
        emit(rType(mipsPkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));  // distance 2 and 1
        emit(rType(mipsPkg::FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0));  // distance 1 and 3
        emit(rType(mipsPkg::FN_AND, 5'd4, 5'd2, 5'd5, 5'd0));
        emit(rType(mipsPkg::FN_OR, 5'd5, 5'd3, 5'd6, 5'd0));
        emit(rType(mipsPkg::FN_SLT, 5'd2, 5'd1, 5'd7, 5'd0));
        emit(rType(mipsPkg::FN_SLT, 5'd1, 5'd5, 5'd8, 5'd0));
        emit(rType(mipsPkg::FN_SLL, 5'd0, 5'd8, 5'd9, 5'd7));
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd2, 16'h0020));
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd3, 16'd77));
        emit(iType(mipsPkg::OP_SW, 5'd2, 5'd3, 16'd8));      // data 1 back, base 2 back
        emit(iType(mipsPkg::OP_LW, 5'd2, 5'd4, 16'd8));
        emit(iType(mipsPkg::OP_SW, 5'd2, 5'd4, 16'd12));     // loaded data 1 back
        emit(iType(mipsPkg::OP_LW, 5'd2, 5'd5, 16'd12));
        emit(rType(mipsPkg::FN_ADDU, 5'd5, 5'd5, 5'd6, 5'd0));  // load then use
        emit(iType(mipsPkg::OP_LW, 5'd2, 5'd6, 16'd0));
        emit(iType(mipsPkg::OP_ADDIU, 5'd1, 5'd1, 16'd1));
        emit(iType(mipsPkg::OP_SW, 5'd2, 5'd6, 16'd16));     // loaded data 2 back
        emit(iType(mipsPkg::OP_SW, 5'd0, 5'd9, 16'd4));
        b = progLen;
        jrTarget = addrOf(b + 25);
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd1, 16'h0020));
        emit(iType(mipsPkg::OP_BEQ, 5'd1, 5'd2, 16'd2));     // taken, operand just computed
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd2, 16'd9));   // delay slot
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd2, 16'd1));   // skipped
        emit(iType(mipsPkg::OP_LW, 5'd0, 5'd3, 16'd4));
        emit(iType(mipsPkg::OP_BNE, 5'd3, 5'd0, 16'd3));     // not taken, just loaded
        emit(iType(mipsPkg::OP_ADDIU, 5'd3, 5'd4, 16'd1));
        emit(iType(mipsPkg::OP_BEQ, 5'd4, 5'd3, 16'd2));     // not taken
        emit(rType(mipsPkg::FN_OR, 5'd4, 5'd3, 5'd5, 5'd0));
        emit(iType(mipsPkg::OP_BNE, 5'd4, 5'd3, 16'd2));     // taken
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd6, 16'd3));
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd6, 16'd4));   // skipped
        emit(jType(mipsPkg::OP_JAL, addrOf(b + 16)));
        emit(rType(mipsPkg::FN_ADDU, 5'd31, 5'd0, 5'd7, 5'd0)); // slot reads the link
        emit(jType(mipsPkg::OP_J, addrOf(b + 19)));           // return lands here
        emit(iType(mipsPkg::OP_ADDIU, 5'd2, 5'd2, 16'd1));
        emit(iType(mipsPkg::OP_ADDIU, 5'd31, 5'd6, 16'd0));  // subroutine
        emit(rType(mipsPkg::FN_JR, 5'd6, 5'd0, 5'd0, 5'd0));
        emit(rType(mipsPkg::FN_SLL, 5'd0, 5'd6, 5'd4, 5'd2));
        emit(iType(mipsPkg::OP_ORI, 5'd0, 5'd9, jrTarget[15:0]));
        emit(iType(mipsPkg::OP_SW, 5'd0, 5'd9, 16'd24));
        emit(iType(mipsPkg::OP_LW, 5'd0, 5'd10, 16'd24));
        emit(rType(mipsPkg::FN_JR, 5'd10, 5'd0, 5'd0, 5'd0)); // jr on a loaded target
        emit(iType(mipsPkg::OP_ADDIU, 5'd10, 5'd11, 16'd4));
        emit(iType(mipsPkg::OP_ADDIU, 5'd0, 5'd11, 16'd0));  // skipped
    endtask

    // small register set, forward-only control flow, never a branch in a delay slot
    task automatic genRandom(input int count);
        int          kind, k, last;
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        logic        afterBranch;
        afterBranch = 1'b0;
        last = progLen + count - 1;
        for (int n = 0; n < count; n++) begin
            kind = $urandom_range(0, 15);
            rs = 5'($urandom_range(0, 7));
            rt = 5'($urandom_range(0, 7));
            rd = 5'($urandom_range(1, 7));
            imm = 16'($urandom);
            k = $urandom_range(1, 6);
            if (kind >= 12 && (afterBranch || progLen == last))
                kind = 6;
            if (progLen + 1 + k > last + 1)
                k = last - progLen;   // at most onto the halt
            case (kind)
                0: emit(rType(mipsPkg::FN_ADDU, rs, rt, rd, 5'd0));
                1: emit(rType(mipsPkg::FN_SUBU, rs, rt, rd, 5'd0));
                2: emit(rType(mipsPkg::FN_AND, rs, rt, rd, 5'd0));
                3: emit(rType(mipsPkg::FN_OR, rs, rt, rd, 5'd0));
                4: emit(rType(mipsPkg::FN_SLT, rs, rt, rd, 5'd0));
                5: emit(rType(mipsPkg::FN_SLL, 5'd0, rt, rd, imm[4:0]));
                6: emit(iType(mipsPkg::OP_ADDIU, rs, rd, imm));
                7: emit(iType(mipsPkg::OP_ORI, rs, rd, imm));
                8: emit(iType(mipsPkg::OP_LUI, 5'd0, rd, imm));
                9, 10: emit(iType(mipsPkg::OP_LW, rs, rd, {8'h00, imm[7:2], 2'b00}));
                11: emit(iType(mipsPkg::OP_SW, rs, rt, {8'h00, imm[7:2], 2'b00}));
                12: emit(iType(mipsPkg::OP_BEQ, rs, rt, 16'(k)));
                13: emit(iType(mipsPkg::OP_BNE, rs, rt, 16'(k)));
                14: emit(jType(mipsPkg::OP_J, addrOf(progLen + 1 + k)));
                default: emit(jType(mipsPkg::OP_JAL, addrOf(progLen + 1 + k)));
            endcase
            afterBranch = kind >= 12;
        end
    endtask

    // one architectural step, target base is the delay slot address
    function automatic void isaStep();
        logic [31:0] inst, rsV, rtV, simm, result, addr, target;
        logic [4:0]  dest;
        logic        write, taken;
        inst = fetchWord(refPc);
        rsV = gpr[inst[25:21]];
        rtV = gpr[inst[20:16]];
        simm = {{16{inst[15]}}, inst[15:0]};
        dest = inst[20:16];
        result = 32'h0;
        write = 1'b0;
        taken = 1'b0;
        target = refNpc + {simm[29:0], 2'b00};
        addr = rsV + simm;
        case (inst[31:26])
            mipsPkg::OP_SPECIAL: begin
                dest = inst[15:11];
                write = 1'b1;
                case (inst[5:0])
                    mipsPkg::FN_ADDU: result = rsV + rtV;
                    mipsPkg::FN_SUBU: result = rsV - rtV;
                    mipsPkg::FN_AND:  result = rsV & rtV;
                    mipsPkg::FN_OR:   result = rsV | rtV;
                    mipsPkg::FN_SLT:  result = {31'd0, $signed(rsV) < $signed(rtV)};
                    mipsPkg::FN_SLL:  result = rtV << inst[10:6];
                    mipsPkg::FN_JR: begin
                        write = 1'b0;
                        taken = 1'b1;
                        target = rsV;
                    end
                    default: write = 1'b0;
                endcase
            end
            mipsPkg::OP_J, mipsPkg::OP_JAL: begin
                taken = 1'b1;
                target = {refNpc[31:28], inst[25:0], 2'b00};
                write = inst[31:26] == mipsPkg::OP_JAL;
                dest = 5'd31;
                result = refPc + 32'd8;   // link skips the delay slot
            end
            mipsPkg::OP_BEQ: taken = rsV == rtV;
            mipsPkg::OP_BNE: taken = rsV != rtV;
            mipsPkg::OP_ADDIU: begin
                write = 1'b1;
                result = rsV + simm;
            end
            mipsPkg::OP_ORI: begin
                write = 1'b1;
                result = rsV | {16'h0000, inst[15:0]};
            end
            mipsPkg::OP_LUI: begin
                write = 1'b1;
                result = {inst[15:0], 16'h0000};
            end
            mipsPkg::OP_LW: begin
                write = 1'b1;
                result = refMem[addr[7:2]];
            end
            mipsPkg::OP_SW: begin
                stQ.push_back({addr, rtV});
                refMem[addr[7:2]] = rtV;
            end
            default: ;
        endcase
        if (write && dest != 5'd0) begin
            gpr[dest] = result;
            wbQ.push_back({refPc, dest, result});
        end
        refPc = refNpc;
        refNpc = taken ? target : refNpc + 32'd4;
    endfunction

    task automatic runModel();
        int steps;
        steps = 0;
        refPc = `MIPS_RESET_PC;
        refNpc = `MIPS_RESET_PC + 32'd4;
        while (refPc != addrOf(haltIdx) && steps <= modelSteps) begin
            isaStep();
            steps++;
        end
        if (steps > modelSteps) begin
            $display("reference model never reached the end of the program");
            stopWithFail();
        end
    endtask

    // compares writebacks and stores in program order
    always @(negedge clk) begin
        logic [68:0] expWb;
        logic [63:0] expSt;
        if (wbEn) begin
            if (posEdges < 4) begin
                $display("writeback at %0t before any instruction could reach it", $time);
                stopWithFail();
            end else if (wbQ.size() == 0) begin
                $display("unexpected writeback to r%0d at %0t", wbNum, $time);
                stopWithFail();
            end else begin
                expWb = wbQ.pop_front();
                checkValue("writeback pc", wbPc, expWb[68:37]);
                checkValue("writeback register", {27'd0, wbNum}, {27'd0, expWb[36:32]});
                checkValue("writeback data", wbData, expWb[31:0]);
            end
        end
        if (dmemWe) begin
            if (posEdges < 3) begin
                $display("store at %0t before any instruction could reach memory", $time);
                stopWithFail();
            end else if (stQ.size() == 0) begin
                $display("unexpected store to %h at %0t", dmemAddr, $time);
                stopWithFail();
            end else begin
                expSt = stQ.pop_front();
                checkValue("store address", dmemAddr, expSt[63:32]);
                checkValue("store data", dmemWdata, expSt[31:0]);
            end
        end
    end

    initial begin
        int cycles;
        clk = 1'b0;
        reset = 1'b1;
        posEdges = 0;
        progLen = 0;
        void'($urandom(88));
        for (int i = 0; i < 32; i++)
            gpr[i] = 32'h0;
        for (int i = 0; i < imemWords; i++)
            imem[i] = 32'h0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
            refMem[i] = fillWord(i);
        end
        buildDirected();
        genRandom(randomCount);
        haltIdx = progLen;
        emit(iType(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'hffff));   // spin at the end
        emit(32'h0000_0000);
        runModel();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        checkValue("first fetch address", imemAddr, `MIPS_RESET_PC);
        cycles = 0;
        while ((wbQ.size() != 0 || stQ.size() != 0) && cycles <= runCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles > runCycles) begin
            $display("timeout with %0d writebacks and %0d stores still expected",
                     wbQ.size(), stQ.size());
            stopWithFail();
        end
        // idle cycles expose extra writebacks or stores
        for (int i = 0; i < 20; i++)
            @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end
endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/mipsPkg.sv
verilog/hazardIf.sv
verilog/controller.sv
verilog/regFile.sv
verilog/alu.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
dv/mipsCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the MIPS core testbench
VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
